//--- eeprom_wr.f
rtl/eeprom_pkg.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_ctrl_fsm.sv
rtl/eeprom_wr.sv
verif/clk_gen.sv
verif/eeprom_model.sv
verif/eeprom_wr_properties.sv
verif/tb_eeprom_wr.sv

//--- rtl/eeprom_ctrl_fsm.sv
module eeprom_ctrl_fsm import eeprom_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [ADDR_W-1:0] addr,
    input  logic [7:0]        data_in,
    output bit_op_t           op,
    output logic [7:0]        tx_byte,
    output logic              last,
    input  logic              op_done,
    input  logic              got_nak,
    input  logic [7:0]        rx_byte,
    output logic [7:0]        data_out,
    output logic              ack,
    output logic              nak,
    output logic              busy
);

    main_state_t       state;
    main_state_t       state_nxt;
    bit_op_t           state_op;
    logic              issue;
    logic              nak_q;
    logic [ADDR_W-1:0] addr_q;
    logic [7:0]        data_q;
    logic              rd_q;

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (wr || rd) begin
                    state_nxt = ready;
                end
            end
            ready:       state_nxt = write_start;
            write_start: if (op_done) state_nxt = ctrl_write;
            ctrl_write:  if (op_done) state_nxt = got_nak ? stop : addr_write;
            addr_write: begin
                if (op_done) begin
                    if (got_nak) begin
                        state_nxt = stop;
                    end else begin
                        state_nxt = rd_q ? read_start : data_write;
                    end
                end
            end
            data_write:  if (op_done) state_nxt = stop; // nak or not, the write ends here
            read_start:  if (op_done) state_nxt = ctrl_read;
            ctrl_read:   if (op_done) state_nxt = got_nak ? stop : data_read;
            data_read:   if (op_done) state_nxt = stop;
            stop:        if (op_done) state_nxt = ackn;
            ackn:        state_nxt = idle;
            default:     state_nxt = idle;
        endcase
    end

    // bus operation and byte for the current state
    always_comb begin
        state_op = op_none;
        tx_byte  = 8'h00;
        case (state)
            write_start, read_start: state_op = op_start;
            ctrl_write: begin
                state_op = op_send;
                tx_byte  = {DEVICE_CODE, addr_q[ADDR_W-1:8], RW_WRITE};
            end
            addr_write: begin
                state_op = op_send;
                tx_byte  = addr_q[7:0];
            end
            data_write: begin
                state_op = op_send;
                tx_byte  = data_q;
            end
            ctrl_read: begin
                state_op = op_send;
                tx_byte  = {DEVICE_CODE, addr_q[ADDR_W-1:8], RW_READ};
            end
            data_read: state_op = op_recv;
            stop:      state_op = op_stop;
            default:   state_op = op_none;
        endcase
    end

    assign op   = issue ? state_op : op_none; // one cycle on state entry
    assign last = (state == data_read);       // single byte read, master naks
    assign ack  = (state == ackn);
    assign nak  = nak_q;
    assign busy = (state != idle);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= idle;
            issue <= 1'b0;
            nak_q <= 1'b0;
        end else begin
            state <= state_nxt;
            issue <= (state_nxt != state) &&
                     (state_nxt inside {write_start, ctrl_write, addr_write, data_write,
                                        read_start, ctrl_read, data_read, stop});
            if (state == ready) begin
                nak_q <= 1'b0;
            end else if (op_done && got_nak) begin
                nak_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state == idle && (wr || rd)) begin
            addr_q <= addr;
            data_q <= data_in;
            rd_q   <= rd; // read wins if both strobes come together
        end
        if (state == data_read && op_done) begin
            data_out <= rx_byte;
        end
    end

endmodule

//--- rtl/eeprom_pkg.sv
package eeprom_pkg;

    localparam int ADDR_W = 11;

    localparam logic [3:0] DEVICE_CODE = 4'b1010; // upper nibble of every control byte
    localparam logic       RW_WRITE    = 1'b0;
    localparam logic       RW_READ     = 1'b1;

    // half periods per bit engine operation
    localparam logic [4:0] PH_SHORT = 5'd4;  // start or stop
    localparam logic [4:0] PH_BYTE  = 5'd18; // 8 data bits and the ack bit

    // sequencer states, one-hot
    typedef enum logic [10:0] {
        idle        = 11'b000_0000_0001,
        ready       = 11'b000_0000_0010,
        write_start = 11'b000_0000_0100,
        ctrl_write  = 11'b000_0000_1000,
        addr_write  = 11'b000_0001_0000,
        data_write  = 11'b000_0010_0000,
        read_start  = 11'b000_0100_0000,
        ctrl_read   = 11'b000_1000_0000,
        data_read   = 11'b001_0000_0000,
        stop        = 11'b010_0000_0000,
        ackn        = 11'b100_0000_0000
    } main_state_t;

    // operations handed to the bit engine
    typedef enum logic [2:0] {
        op_none  = 3'd0,
        op_start = 3'd1, // also the repeated start
        op_stop  = 3'd2,
        op_send  = 3'd3,
        op_recv  = 3'd4
    } bit_op_t;

endpackage

//--- rtl/eeprom_wr.sv
module eeprom_wr import eeprom_pkg::*; #(
    parameter int unsigned CLK_DIV = 2
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  logic [ADDR_W-1:0] addr,
    input  logic [7:0]        data_in,
    output logic [7:0]        data_out,
    output logic              ack,
    output logic              nak,
    output logic              busy,
    output logic              scl,
    inout  wire               sda
);

    bit_op_t    op;
    logic [7:0] tx_byte;
    logic       last;
    logic       op_done;
    logic       got_nak;
    logic [7:0] rx_byte;
    logic       sda_oe;
    logic       sda_in;

    // open drain, the pull-up gives the high level
    assign sda    = sda_oe ? 1'b0 : 1'bz;
    assign sda_in = sda;

    eeprom_ctrl_fsm ctrl_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .data_in  (data_in),
        .op       (op),
        .tx_byte  (tx_byte),
        .last     (last),
        .op_done  (op_done),
        .got_nak  (got_nak),
        .rx_byte  (rx_byte),
        .data_out (data_out),
        .ack      (ack),
        .nak      (nak),
        .busy     (busy)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) bit_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .op      (op),
        .tx_byte (tx_byte),
        .last    (last),
        .op_done (op_done),
        .got_nak (got_nak),
        .rx_byte (rx_byte),
        .scl     (scl),
        .sda_oe  (sda_oe),
        .sda_in  (sda_in)
    );

endmodule

//--- rtl/i2c_bit_engine.sv
module i2c_bit_engine import eeprom_pkg::*; #(
    parameter int unsigned CLK_DIV = 2
) (
    input  logic       CLK,
    input  logic       RESET,
    input  bit_op_t    op,
    input  logic [7:0] tx_byte,
    input  logic       last,
    output logic       op_done,
    output logic       got_nak,
    output logic [7:0] rx_byte,
    output logic       scl,
    output logic       sda_oe,
    input  logic       sda_in
);

    localparam logic [31:0] DIV_LAST  = 32'(CLK_DIV - 1);
    localparam logic [31:0] SAMPLE_AT = 32'(CLK_DIV / 2); // middle of the high phase
    // with more than one CLK per half period, sda moves one CLK after scl
    localparam bit          SDA_LAG   = (CLK_DIV > 1);

    bit_op_t     cur_op;
    logic        active;
    logic [4:0]  phase;
    logic [4:0]  phase_nxt;
    logic [4:0]  phase_end;
    logic [31:0] div_cnt;
    logic [7:0]  tx_q;
    logic        last_q;
    logic [7:0]  rx_sh;
    logic        tick;
    logic        sample;
    logic [1:0]  lvl_start;
    logic [1:0]  lvl_now;
    logic [1:0]  lvl_next;

    // {scl, sda_oe} wanted in a given phase of an operation
    function automatic logic [1:0] bus_level(bit_op_t o, logic [4:0] ph,
                                             logic [7:0] d, logic lst);
        logic hi;
        logic oe;
        hi = ph[0]; // bytes: low on even, high on odd phases
        oe = 1'b0;
        case (o)
            op_start: begin
                hi = (ph == 5'd1) || (ph == 5'd2);
                oe = ph[1]; // sda falls while scl high
            end
            op_stop: begin
                hi = (ph != 5'd0);
                oe = (ph < 5'd2); // sda rises while scl high
            end
            op_send: oe = !ph[4] && !d[3'd7 - ph[3:1]]; // ack bit left to the slave
            op_recv: oe = ph[4] && !lst;                // master ack unless last byte
            default: oe = 1'b0;
        endcase
        return {hi, oe};
    endfunction

    assign tick      = active && (div_cnt == DIV_LAST);
    assign sample    = active && phase[0] && (div_cnt == SAMPLE_AT);
    assign phase_nxt = phase + 5'd1;
    assign phase_end = (cur_op == op_start || cur_op == op_stop) ? PH_SHORT - 5'd1
                                                                 : PH_BYTE - 5'd1;

    assign lvl_start = bus_level(op, 5'd0, tx_byte, last);
    assign lvl_now   = bus_level(cur_op, phase, tx_q, last_q);
    assign lvl_next  = bus_level(cur_op, phase_nxt, tx_q, last_q);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            active  <= 1'b0;
            cur_op  <= op_none;
            phase   <= '0;
            div_cnt <= '0;
            op_done <= 1'b0;
            got_nak <= 1'b0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
        end else begin
            op_done <= 1'b0;
            if (!active) begin
                if (op != op_none) begin
                    active  <= 1'b1;
                    cur_op  <= op;
                    phase   <= '0;
                    div_cnt <= '0;
                    got_nak <= 1'b0;
                    scl     <= lvl_start[1];
                    if (!SDA_LAG) begin
                        sda_oe <= lvl_start[0];
                    end
                end
            end else begin
                if (tick) begin
                    div_cnt <= '0;
                    if (phase == phase_end) begin
                        active  <= 1'b0; // scl and sda hold until the next op
                        op_done <= 1'b1;
                    end else begin
                        phase <= phase_nxt;
                        scl   <= lvl_next[1];
                        if (!SDA_LAG) begin
                            sda_oe <= lvl_next[0];
                        end
                    end
                end else begin
                    div_cnt <= div_cnt + 32'd1;
                end
                if (SDA_LAG && div_cnt == '0) begin
                    sda_oe <= lvl_now[0];
                end
                // slave acknowledge, high means refused
                if (sample && cur_op == op_send && phase == PH_BYTE - 5'd1) begin
                    got_nak <= sda_in;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!active && op != op_none) begin
            tx_q   <= tx_byte;
            last_q <= last;
        end
        if (sample && cur_op == op_recv && !phase[4]) begin
            rx_sh <= {rx_sh[6:0], sda_in}; // msb first
        end
        if (tick && phase == phase_end && cur_op == op_recv) begin
            rx_byte <= rx_sh;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_eeprom_wr -f eeprom_wr.f -o sim_eeprom_wr
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_eeprom_wr +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation done"
exit 0

//--- verif/clk_gen.sv
module clk_gen #(
    parameter int PERIOD = 20
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
    end

    always #(PERIOD / 2) CLK = ~CLK;

endmodule

//--- verif/eeprom_model.sv
module eeprom_model (
    input  logic CLK,
    input  logic RESET, // clears bus state only, memory is kept
    input  logic scl,
    inout  wire  sda
);

    logic [7:0]  mem [0:2047];
    logic        scl_q;
    logic        sda_q;
    logic        sda_now;
    logic        drive_low;
    logic        active;
    logic        skip_fall;
    logic        reading;
    logic        to_read;
    logic        master_nak;
    logic        wrote;
    logic        write_pending = 1'b0; // set by a completed write
    logic [3:0]  cnt;
    logic [1:0]  byte_idx;
    logic [7:0]  shreg;
    logic [7:0]  tx;
    logic [7:0]  wdata;
    logic [10:0] ptr;

    assign sda     = drive_low ? 1'b0 : 1'bz;
    assign sda_now = (sda !== 1'b0);

    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 8'(i[7:0] * 8'd5) ^ {i[10:8], i[10:8], 2'b01};
        end
    end

    always @(posedge CLK) begin
        scl_q <= scl;
        sda_q <= sda_now;
        if (RESET) begin
            active    <= 1'b0;
            drive_low <= 1'b0;
            reading   <= 1'b0;
            to_read   <= 1'b0;
            wrote     <= 1'b0;
        end else if (scl && scl_q && sda_q && !sda_now) begin // start or repeated start
            active     <= 1'b1;
            skip_fall  <= 1'b1;
            cnt        <= '0;
            byte_idx   <= '0;
            reading    <= 1'b0;
            to_read    <= 1'b0;
            drive_low  <= 1'b0;
            master_nak <= 1'b0;
        end else if (scl && scl_q && !sda_q && sda_now) begin // stop
            if (wrote) begin
                mem[ptr]      <= wdata;
                write_pending <= 1'b1;
            end
            wrote     <= 1'b0;
            active    <= 1'b0;
            reading   <= 1'b0;
            drive_low <= 1'b0;
        end else if (active && scl && !scl_q) begin
            if (!reading && cnt < 4'd8) begin
                shreg <= {shreg[6:0], sda_now};
            end
            if (reading && cnt == 4'd8) begin
                master_nak <= sda_now;
            end
        end else if (active && !scl && scl_q) begin
            if (skip_fall) begin
                skip_fall <= 1'b0; // scl drop that ends the start
            end else if (cnt == 4'd7) begin
                cnt       <= 4'd8;
                drive_low <= 1'b0;
                if (!reading) begin
                    case (byte_idx)
                        2'd0: begin
                            if (shreg[7:4] != 4'b1010 || write_pending) begin
                                write_pending <= 1'b0; // refused, still busy writing
                                active        <= 1'b0;
                            end else begin
                                drive_low <= 1'b1;
                                byte_idx  <= 2'd1;
                                if (shreg[0]) begin
                                    to_read <= 1'b1;
                                    tx      <= mem[{shreg[3:1], ptr[7:0]}];
                                end else begin
                                    ptr[10:8] <= shreg[3:1];
                                end
                            end
                        end
                        2'd1: begin
                            ptr[7:0]  <= shreg;
                            drive_low <= 1'b1;
                            byte_idx  <= 2'd2;
                        end
                        2'd2: begin
                            wdata     <= shreg;
                            wrote     <= 1'b1;
                            drive_low <= 1'b1;
                            byte_idx  <= 2'd3;
                        end
                        default: active <= 1'b0; // no page writes
                    endcase
                end
            end else if (cnt == 4'd8) begin
                cnt <= '0;
                if (to_read) begin
                    to_read   <= 1'b0;
                    reading   <= 1'b1;
                    drive_low <= !tx[7];
                end else begin
                    drive_low <= 1'b0;
                    if (reading) begin
                        active  <= 1'b0; // single byte reads only
                        reading <= 1'b0;
                    end
                end
            end else begin
                cnt       <= cnt + 4'd1;
                drive_low <= reading ? !tx[3'(6 - cnt)] : 1'b0;
            end
        end
    end

endmodule

//--- verif/eeprom_wr_properties.sv
module eeprom_wr_properties import eeprom_pkg::*; (
    input logic    CLK,
    input logic    RESET,
    input logic    scl,
    input logic    sda_in,
    input logic    ack,
    input logic    busy,
    input bit_op_t op
);

    bit_op_t last_op;
    int      fail_count = 0;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            last_op <= op_none;
        end else if (op != op_none) begin
            last_op <= op;
        end else if (ack) begin
            last_op <= op_none; // bus idle between transactions
        end
    end

    // data moves only while scl is low
    sda_stable_a: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && sda_in != $past(sda_in)) |-> (last_op inside {op_start, op_stop}))
        else begin
            fail_count++;
            $error("sda changed while scl high outside start or stop");
        end

    ack_one_cycle_a: assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
        else begin
            fail_count++;
            $error("ack wider than one cycle");
        end

    busy_reset_a: assert property (@(posedge CLK) RESET |=> !busy)
        else begin
            fail_count++;
            $error("busy high after reset");
        end

endmodule

bind eeprom_wr eeprom_wr_properties props_i (
    .CLK    (CLK),
    .RESET  (RESET),
    .scl    (scl),
    .sda_in (sda_in),
    .ack    (ack),
    .busy   (busy),
    .op     (op)
);

//--- verif/tb_eeprom_wr.sv
module tb_eeprom_wr import eeprom_pkg::*; ;

    localparam int CLK_DIV   = 2;
    localparam int NUM_RAND  = 64;
    localparam int OP_CYCLES = 120 * CLK_DIV + 40; // worst transaction is 84 half periods
    localparam int RUN_TIME  = 2 * (NUM_RAND + 20) * OP_CYCLES * 20;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        data_in;
    logic [7:0]        data_out;
    logic              ack;
    logic              nak;
    logic              busy;
    logic              scl;
    wire               sda;

    logic [7:0]        ref_mem [0:2047];
    logic              ref_pending; // a completed write makes the device refuse once
    int                errors;
    int                checks;
    logic [ADDR_W-1:0] last_addr;

    clk_gen #(.PERIOD(20)) clk_gen_i (.CLK(CLK));

    pullup (sda);

    eeprom_wr #(.CLK_DIV(CLK_DIV)) eeprom_wr_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (data_out),
        .ack      (ack),
        .nak      (nak),
        .busy     (busy),
        .scl      (scl),
        .sda      (sda)
    );

    eeprom_model model_i (.CLK(CLK), .RESET(RESET), .scl(scl), .sda(sda));

    task automatic report_mismatch(string what, int got, int exp);
        errors++;
        $display("MISMATCH at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    endtask

    task automatic check_idle(string where);
        checks++;
        if (busy || ack) begin
            errors++;
            $display("busy or ack high on an idle bus %s", where);
        end
        if (scl !== 1'b1 || sda !== 1'b1) begin
            errors++;
            $display("serial bus not released %s", where);
        end
    endtask

    // one strobe, with a stray strobe while busy that must be ignored
    task automatic run_op(input logic is_rd, input logic [ADDR_W-1:0] a, input logic [7:0] d,
                          output logic got_nak, output logic [7:0] got_data);
        logic inject;
        logic done;
        int   inject_at;
        int   cyc;
        inject    = 1'b0;
        done      = 1'b0;
        cyc       = 0;
        inject_at = $urandom_range(60, 2);
        got_nak   = 1'b0;
        got_data  = 8'h00;
        while (busy) @(negedge CLK);
        @(posedge CLK);
        wr      <= !is_rd;
        rd      <= is_rd;
        addr    <= a;
        data_in <= d;
        while (!done) begin
            @(posedge CLK);
            wr <= inject;
            rd <= 1'b0;
            if (inject) begin
                addr    <= ADDR_W'($urandom);
                data_in <= 8'($urandom);
            end
            @(negedge CLK);
            if (ack) begin
                done     = 1'b1;
                got_nak  = nak;
                got_data = data_out;
            end
            inject = !ack && busy && (cyc == inject_at);
            cyc++;
        end
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        @(negedge CLK);
        checks++;
        if (ack || busy) begin
            errors++;
            $display("ack or busy still high in the cycle after ack at time %0t", $time);
        end
    endtask

    task automatic expect_op(input logic is_rd, input logic [ADDR_W-1:0] a,
                             input logic [7:0] d);
        logic       exp_nak;
        logic [7:0] exp_data;
        logic       got_nak;
        logic [7:0] got_data;
        exp_nak  = ref_pending;
        exp_data = ref_mem[a];
        if (ref_pending) begin
            ref_pending = 1'b0;
        end else if (!is_rd) begin
            ref_mem[a]  = d;
            ref_pending = 1'b1;
        end
        run_op(is_rd, a, d, got_nak, got_data);
        checks++;
        if (got_nak !== exp_nak) begin
            report_mismatch($sformatf("nak on %s at %03h", is_rd ? "read" : "write", a),
                            got_nak, exp_nak);
        end
        if (is_rd && !exp_nak && got_data !== exp_data) begin
            report_mismatch($sformatf("read data at %03h", a), got_data, exp_data);
        end
        if (is_rd && !exp_nak && model_i.master_nak !== 1'b1) begin
            report_mismatch($sformatf("master nak after read data at %03h", a),
                            model_i.master_nak, 1);
        end
    endtask

    initial begin
        #(RUN_TIME);
        $display("timeout: the run did not finish within %0d time units", RUN_TIME);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [ADDR_W-1:0] a;
        void'($urandom(32'h166df8a8));
        errors      = 0;
        checks      = 0;
        ref_pending = 1'b0;
        last_addr   = '0;
        for (int i = 0; i < 2048; i++) begin
            ref_mem[i] = 8'(i[7:0] * 8'd5) ^ {i[10:8], i[10:8], 2'b01};
        end
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        data_in = '0;
        repeat (3) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        check_idle("after reset");

        // write, refused read, then the retry
        expect_op(1'b0, 11'h5a3, 8'h3c);
        expect_op(1'b1, 11'h5a3, 8'h00);
        expect_op(1'b1, 11'h5a3, 8'h00);
        // refused write leaves the memory alone
        expect_op(1'b0, 11'h0f0, 8'ha5);
        expect_op(1'b0, 11'h0f0, 8'h11);
        expect_op(1'b1, 11'h0f0, 8'h00);

        for (int i = 0; i < NUM_RAND; i++) begin
            a = {3'(i), 8'($urandom)}; // walks all eight blocks
            if ($urandom_range(2, 0) == 0) begin
                a = last_addr;
            end
            last_addr = a;
            expect_op(1'($urandom_range(1, 0)), a, 8'($urandom));
        end

        // reset in the middle of a read
        expect_op(1'b1, 11'h123, 8'h00);
        @(posedge CLK);
        rd   <= 1'b1;
        addr <= 11'h7ff;
        @(posedge CLK);
        rd <= 1'b0;
        repeat ($urandom_range(150, 40)) @(negedge CLK);
        checks++;
        if (!busy) begin
            errors++;
            $display("read already finished before the second reset");
        end
        @(posedge CLK);
        RESET <= 1'b1;
        repeat (3) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        check_idle("after reset in a transaction");
        expect_op(1'b0, 11'h321, 8'h77);
        expect_op(1'b1, 11'h321, 8'h00);
        expect_op(1'b1, 11'h321, 8'h00);

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, eeprom_wr_i.props_i.fail_count);
        if (errors == 0 && eeprom_wr_i.props_i.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
